// ==== ps2_line_pkg.sv ====
// PS/2 line protocol definitions
// inhibit timing, frame state encoding and the sampled-line bundle

package ps2_line_pkg;

    // system clock and the 100 us clock inhibit before a host transmit
    localparam int CLK_HZ = 10_000_000;
    localparam int INHIBIT_CYCLES = (CLK_HZ / 1_000_000) * 100;
    localparam int INHIBIT_W = $clog2(INHIBIT_CYCLES + 1);

    typedef enum logic [3:0] {
        state_idle,
        // device to host
        state_rx,
        state_rx_parity,
        state_stop,
        // host to device
        state_inhibit,
        state_tx_start,
        state_tx,
        state_tx_parity,
        state_tx_stop,
        state_tx_ack
    } frame_state_t;

    // synchronized line levels plus the strobe the host samples on
    typedef struct packed {
        logic clk_level;
        logic dat_level;
        logic clk_fall;
    } line_sample_t;

endpackage

// ==== ps2_host_pkg.sv ====
// host-side PS/2 data definitions
// data byte, receive queue entry and queue sizing

package ps2_host_pkg;

    typedef logic [7:0] ps2_byte_t;

    // one received frame as seen by the host
    typedef struct packed {
        ps2_byte_t data;
        logic      parity_error;
    } rx_entry_t;

    // receive queue sizing, depth must stay a power of two
    localparam int RX_DEPTH = 4;
    localparam int RX_PTR_W = $clog2(RX_DEPTH);

endpackage

// ==== ps2_line_sampler.sv ====
// PS/2 line sampler
// synchronizes clock and data, strobes on falling clock edges

`timescale 1ns/1ps

module ps2_line_sampler (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ps2_clk_in,
    input  logic                       ps2_dat_in,
    output ps2_line_pkg::line_sample_t line
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;

    // all flops start at the idle line level so reset gives no edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk_in};
            dat_sync <= {dat_sync[0], ps2_dat_in};
            clk_prev <= clk_sync[1];
        end
    end

    assign line = '{clk_level: clk_sync[1],
                    dat_level: dat_sync[1],
                    clk_fall:  clk_prev & ~clk_sync[1]};

endmodule

// ==== ps2_host.sv ====
// PS/2 host frame engine
// receives device frames with odd parity check, sends command bytes
// after a clock inhibit and start bit

`timescale 1ns/1ps

module ps2_host (
    input  logic                       clk,
    input  logic                       reset,
    input  ps2_line_pkg::line_sample_t line,
    input  logic                       start_tx,
    input  ps2_host_pkg::ps2_byte_t    tx_data,
    output ps2_host_pkg::rx_entry_t    rx_entry,
    output logic                       rx_valid,
    output logic                       tx_busy,
    output logic                       tx_complete,
    output logic                       ps2_clk_out,
    output logic                       ps2_dat_out
);

    ps2_line_pkg::frame_state_t         state;
    ps2_line_pkg::frame_state_t         next_state;
    logic [ps2_line_pkg::INHIBIT_W-1:0] inhibit_count;
    logic [2:0]                         bit_pos;
    ps2_host_pkg::ps2_byte_t            rx_shift;
    ps2_host_pkg::ps2_byte_t            tx_reg;
    logic                               parity_error;
    logic                               dat_reg;
    logic                               sample;
    logic                               last_bit;

    // the host samples and shifts on the device's falling clock edge
    assign sample   = line.clk_fall;
    assign last_bit = bit_pos == 3'd7;

    always_comb begin
        next_state = state;
        case (state)
            ps2_line_pkg::state_idle: begin
                // low data on a clock fall is the start bit
                if (sample && !line.dat_level)
                    next_state = ps2_line_pkg::state_rx;
            end
            ps2_line_pkg::state_rx: begin
                if (sample && last_bit)
                    next_state = ps2_line_pkg::state_rx_parity;
            end
            ps2_line_pkg::state_rx_parity: begin
                if (sample)
                    next_state = ps2_line_pkg::state_stop;
            end
            ps2_line_pkg::state_stop: begin
                if (sample)
                    next_state = ps2_line_pkg::state_idle;
            end
            ps2_line_pkg::state_inhibit: begin
                if (~|inhibit_count)
                    next_state = ps2_line_pkg::state_tx_start;
            end
            ps2_line_pkg::state_tx_start: begin
                next_state = ps2_line_pkg::state_tx;
            end
            ps2_line_pkg::state_tx: begin
                if (sample && last_bit)
                    next_state = ps2_line_pkg::state_tx_parity;
            end
            ps2_line_pkg::state_tx_parity: begin
                if (sample)
                    next_state = ps2_line_pkg::state_tx_stop;
            end
            ps2_line_pkg::state_tx_stop: begin
                if (sample)
                    next_state = ps2_line_pkg::state_tx_ack;
            end
            ps2_line_pkg::state_tx_ack: begin
                if (sample)
                    next_state = ps2_line_pkg::state_idle;
            end
            default: begin
                next_state = ps2_line_pkg::state_idle;
            end
        endcase

        // a send request wins over anything in flight, receive included
        if (start_tx)
            next_state = ps2_line_pkg::state_inhibit;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= ps2_line_pkg::state_idle;
        else
            state <= next_state;
    end

    // counts down while the clock line is held low
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            inhibit_count <= ps2_line_pkg::INHIBIT_CYCLES[ps2_line_pkg::INHIBIT_W-1:0];
        else if (state == ps2_line_pkg::state_inhibit && !start_tx)
            inhibit_count <= inhibit_count - 1'b1;
        else
            inhibit_count <= ps2_line_pkg::INHIBIT_CYCLES[ps2_line_pkg::INHIBIT_W-1:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            bit_pos <= 3'd0;
        else if (state == ps2_line_pkg::state_rx || state == ps2_line_pkg::state_tx) begin
            if (sample)
                bit_pos <= bit_pos + 3'd1;
        end else
            bit_pos <= 3'd0;
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == ps2_line_pkg::state_rx && sample)
            rx_shift <= {line.dat_level, rx_shift[7:1]};
    end

    // odd parity over data and parity bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            parity_error <= 1'b0;
        else if (state == ps2_line_pkg::state_idle)
            parity_error <= 1'b0;
        else if (state == ps2_line_pkg::state_rx_parity && sample)
            parity_error <= ~^{rx_shift, line.dat_level};
    end

    always_ff @(posedge clk) begin
        if (start_tx)
            tx_reg <= tx_data;
    end

    // start bit goes out as the clock is released, later bits on each fall
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            dat_reg <= 1'b1;
        else if (next_state == ps2_line_pkg::state_tx_start)
            dat_reg <= 1'b0;
        else if (state == ps2_line_pkg::state_idle || state == ps2_line_pkg::state_inhibit)
            dat_reg <= 1'b1;
        else if (sample) begin
            case (state)
                ps2_line_pkg::state_tx:        dat_reg <= tx_reg[bit_pos];
                ps2_line_pkg::state_tx_parity: dat_reg <= ~^tx_reg;
                ps2_line_pkg::state_tx_stop:   dat_reg <= 1'b1;
                default:                       dat_reg <= dat_reg;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            tx_busy <= 1'b0;
        else if (start_tx)
            tx_busy <= 1'b1;
        else if (state == ps2_line_pkg::state_idle)
            tx_busy <= 1'b0;
    end

    assign rx_valid    = state == ps2_line_pkg::state_stop && sample;
    assign tx_complete = state == ps2_line_pkg::state_tx_ack && sample;
    assign rx_entry    = '{data: rx_shift, parity_error: parity_error};

    // a low output pulls the pin down
    assign ps2_clk_out = state != ps2_line_pkg::state_inhibit;
    assign ps2_dat_out = dat_reg;

endmodule

// ==== ps2_rx_queue.sv ====
// receive queue for PS/2 frames
// show-ahead circular buffer with sticky overflow

`timescale 1ns/1ps

module ps2_rx_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_valid,
    input  ps2_host_pkg::rx_entry_t wr_entry,
    input  logic                    rx_pop,
    output ps2_host_pkg::rx_entry_t rx_entry,
    output logic                    rx_empty,
    output logic                    overflow
);

    ps2_host_pkg::rx_entry_t             mem [ps2_host_pkg::RX_DEPTH];
    logic [ps2_host_pkg::RX_PTR_W-1:0]   wr_ptr;
    logic [ps2_host_pkg::RX_PTR_W-1:0]   rd_ptr;
    logic [ps2_host_pkg::RX_PTR_W:0]     count;
    logic                                full;
    logic                                do_write;
    logic                                do_pop;

    assign full     = count == ps2_host_pkg::RX_DEPTH[ps2_host_pkg::RX_PTR_W:0];
    assign rx_empty = count == '0;
    assign do_write = wr_valid && !full;
    assign do_pop   = rx_pop && !rx_empty;

    // head is always presented
    assign rx_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= wr_entry;
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a byte arriving while full is lost, remember it until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            overflow <= 1'b0;
        else if (wr_valid && full)
            overflow <= 1'b1;
    end

endmodule

// ==== ps2_port_top.sv ====
// PS/2 host port top level
// line sampler, frame engine and receive queue

`timescale 1ns/1ps

module ps2_port_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_pop,
    input  logic                    start_tx,
    input  ps2_host_pkg::ps2_byte_t tx_data,
    output ps2_host_pkg::rx_entry_t rx_entry,
    output logic                    rx_empty,
    output logic                    overflow,
    output logic                    tx_busy,
    output logic                    tx_complete,
    input  logic                    ps2_clk_in,
    input  logic                    ps2_dat_in,
    output logic                    ps2_clk_out,
    output logic                    ps2_dat_out
);

    ps2_line_pkg::line_sample_t line;
    ps2_host_pkg::rx_entry_t    host_entry;
    logic                       host_rx_valid;

    ps2_line_sampler u_sampler (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk_in (ps2_clk_in),
        .ps2_dat_in (ps2_dat_in),
        .line       (line)
    );

    ps2_host u_host (
        .clk         (clk),
        .reset       (reset),
        .line        (line),
        .start_tx    (start_tx),
        .tx_data     (tx_data),
        .rx_entry    (host_entry),
        .rx_valid    (host_rx_valid),
        .tx_busy     (tx_busy),
        .tx_complete (tx_complete),
        .ps2_clk_out (ps2_clk_out),
        .ps2_dat_out (ps2_dat_out)
    );

    // every received frame goes to the queue, even when it is full
    ps2_rx_queue u_queue (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (host_rx_valid),
        .wr_entry (host_entry),
        .rx_pop   (rx_pop),
        .rx_entry (rx_entry),
        .rx_empty (rx_empty),
        .overflow (overflow)
    );

endmodule

// ==== ps2_port_chk.sv ====
// concurrent assertions on the PS/2 frame engine
// strobe widths and line levels against the frame state

`timescale 1ns/1ps

module ps2_port_chk (
    input logic                       clk,
    input logic                       reset,
    input ps2_line_pkg::frame_state_t state,
    input logic                       rx_valid,
    input logic                       tx_complete,
    input logic                       ps2_clk_out,
    input logic                       ps2_dat_out
);

    int fail_count = 0;

    // strobes last a single cycle
    rx_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else begin
            fail_count = fail_count + 1;
            $error("rx_valid held longer than one cycle");
        end

    tx_complete_pulse: assert property (@(posedge clk) disable iff (reset)
        tx_complete |=> !tx_complete)
        else begin
            fail_count = fail_count + 1;
            $error("tx_complete held longer than one cycle");
        end

    // the clock line is released only after the full inhibit time
    clk_low_for_inhibit: assert property (@(posedge clk) disable iff (reset)
        $rose(ps2_clk_out) |-> $past(!ps2_clk_out, ps2_line_pkg::INHIBIT_CYCLES))
        else begin
            fail_count = fail_count + 1;
            $error("clock line released before the inhibit time ran out");
        end

    dat_high_in_idle: assert property (@(posedge clk) disable iff (reset)
        state == ps2_line_pkg::state_idle |-> ps2_dat_out)
        else begin
            fail_count = fail_count + 1;
            $error("data line low while idle");
        end

endmodule

bind ps2_host ps2_port_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .rx_valid    (rx_valid),
    .tx_complete (tx_complete),
    .ps2_clk_out (ps2_clk_out),
    .ps2_dat_out (ps2_dat_out)
);

// ==== tb_ps2_port.sv ====
// directed testbench for the PS/2 host port
// device model, LFSR byte source, compare tasks and a cycle watchdog

`timescale 1ns/1ps

module tb_ps2_port;

    localparam int BIT_CYCLES = 40;
    localparam int NUM_FRAMES = 11;
    localparam int FRAME_CYCLES = ps2_line_pkg::INHIBIT_CYCLES + 12 * BIT_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    rx_pop;
    logic                    start_tx;
    ps2_host_pkg::ps2_byte_t tx_data;
    ps2_host_pkg::rx_entry_t rx_entry;
    logic                    rx_empty;
    logic                    overflow;
    logic                    tx_busy;
    logic                    tx_complete;
    logic                    ps2_clk_in;
    logic                    ps2_dat_in;
    logic                    ps2_clk_out;
    logic                    ps2_dat_out;
    logic [31:0]             lfsr_state;
    int                      cycle_count = 0;
    int                      complete_count = 0;

    ps2_port_top u_ps2_port_top (
        .clk         (clk),
        .reset       (reset),
        .rx_pop      (rx_pop),
        .start_tx    (start_tx),
        .tx_data     (tx_data),
        .rx_entry    (rx_entry),
        .rx_empty    (rx_empty),
        .overflow    (overflow),
        .tx_busy     (tx_busy),
        .tx_complete (tx_complete),
        .ps2_clk_in  (ps2_clk_in),
        .ps2_dat_in  (ps2_dat_in),
        .ps2_clk_out (ps2_clk_out),
        .ps2_dat_out (ps2_dat_out)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("Verification failed");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_with_failure("timeout, the tests did not finish within the cycle limit");
    end

    // tx_complete comes from flops and is stable at the falling edge
    always @(negedge clk) begin
        if (tx_complete === 1'b1)
            complete_count = complete_count + 1;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output ps2_host_pkg::ps2_byte_t b);
        b = '0;
        repeat (8) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_entry(input ps2_host_pkg::rx_entry_t got,
                               input ps2_host_pkg::rx_entry_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s data %h parity_error %b, expected data %h parity_error %b",
                     $time, what, got.data, got.parity_error, exp.data, exp.parity_error);
            stop_with_failure("wrong receive entry");
        end
    endtask

    task automatic check_byte(input ps2_host_pkg::ps2_byte_t got,
                              input ps2_host_pkg::ps2_byte_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure("wrong byte value");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure("wrong flag value");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // device frame of start bit, data LSB first, parity and stop
    // data changes mid high phase and the host samples after the fall
    task automatic device_send_frame(input ps2_host_pkg::ps2_byte_t data, input logic flip);
        logic [10:0] bits;
        bits = {1'b1, ~^data ^ flip, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            wait_cycles(BIT_CYCLES / 4);
            ps2_dat_in = bits[i];
            wait_cycles(BIT_CYCLES / 4);
            ps2_clk_in = 1'b0;
            wait_cycles(BIT_CYCLES / 2);
            ps2_clk_in = 1'b1;
        end
        ps2_dat_in = 1'b1;
        wait_cycles(BIT_CYCLES);
    endtask

    // one device clock pulse with host data read at the rising edge
    task automatic device_clock_pulse(output logic seen);
        wait_cycles(BIT_CYCLES / 2);
        ps2_clk_in = 1'b0;
        wait_cycles(BIT_CYCLES / 2);
        seen = ps2_dat_out;
        ps2_clk_in = 1'b1;
    endtask

    task automatic pop_entry();
        rx_pop = 1'b1;
        @(negedge clk);
        rx_pop = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_reset_values();
        check_flag(rx_empty, 1'b1, "rx_empty after reset");
        check_flag(overflow, 1'b0, "overflow after reset");
        check_flag(tx_busy, 1'b0, "tx_busy after reset");
        check_flag(tx_complete, 1'b0, "tx_complete after reset");
        check_flag(ps2_clk_out, 1'b1, "ps2_clk_out after reset");
        check_flag(ps2_dat_out, 1'b1, "ps2_dat_out after reset");
    endtask

    task automatic test_receive(input logic flip);
        ps2_host_pkg::ps2_byte_t data;
        random_byte(data);
        device_send_frame(data, flip);
        while (rx_empty)
            @(negedge clk);
        check_entry(rx_entry, '{data: data, parity_error: flip}, "received frame");
        pop_entry();
        check_flag(rx_empty, 1'b1, "rx_empty after pop");
    endtask

    task automatic test_transmit();
        ps2_host_pkg::ps2_byte_t data;
        ps2_host_pkg::ps2_byte_t got;
        logic [10:0]             seen;
        int                      low_cycles;
        random_byte(data);
        complete_count = 0;
        start_tx = 1'b1;
        tx_data = data;
        @(negedge clk);
        start_tx = 1'b0;
        check_flag(tx_busy, 1'b1, "tx_busy after start_tx");
        low_cycles = 0;
        while (!ps2_clk_out) begin
            low_cycles = low_cycles + 1;
            @(negedge clk);
        end
        check_flag(low_cycles >= ps2_line_pkg::INHIBIT_CYCLES - 1 &&
                   low_cycles <= ps2_line_pkg::INHIBIT_CYCLES + 1, 1'b1, "inhibit length ok");
        check_flag(ps2_dat_out, 1'b0, "start bit");
        for (int i = 0; i < 11; i++)
            device_clock_pulse(seen[i]);
        got = seen[7:0];
        check_byte(got, data, "transmitted byte");
        // byte and parity bit together carry an odd number of ones
        check_flag(^{data, seen[8]}, 1'b1, "odd parity of byte and parity bit");
        check_flag(seen[9], 1'b1, "released data line");
        while (tx_busy)
            @(negedge clk);
        check_flag(complete_count == 1, 1'b1, "single tx_complete pulse");
        check_flag(ps2_dat_out, 1'b1, "ps2_dat_out after transmit");
    endtask

    task automatic test_overflow();
        ps2_host_pkg::ps2_byte_t sent [ps2_host_pkg::RX_DEPTH + 2];
        for (int i = 0; i < ps2_host_pkg::RX_DEPTH + 2; i++) begin
            random_byte(sent[i]);
            device_send_frame(sent[i], 1'b0);
            if (i == ps2_host_pkg::RX_DEPTH - 1)
                check_flag(overflow, 1'b0, "overflow with a full queue");
        end
        check_flag(overflow, 1'b1, "overflow after dropped bytes");
        // only the first RX_DEPTH bytes were kept
        for (int i = 0; i < ps2_host_pkg::RX_DEPTH; i++) begin
            check_flag(rx_empty, 1'b0, "rx_empty before pop");
            check_entry(rx_entry, '{data: sent[i], parity_error: 1'b0}, "queued frame");
            pop_entry();
        end
        check_flag(rx_empty, 1'b1, "rx_empty after draining");
    endtask

    initial begin
        reset = 1'b1;
        rx_pop = 1'b0;
        start_tx = 1'b0;
        tx_data = '0;
        ps2_clk_in = 1'b1;
        ps2_dat_in = 1'b1;
        lfsr_state = 32'h75aa;
        wait_cycles(16);
        reset = 1'b0;
        @(negedge clk);
        test_reset_values();
        repeat (3)
            test_receive(1'b0);
        test_receive(1'b1);
        test_transmit();
        test_overflow();
        wait_cycles(4);
        if (u_ps2_port_top.u_host.u_chk.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("the bound checker reported assertion failures");
        end
    end

endmodule

// ==== sim.f ====
ps2_line_pkg.sv
ps2_host_pkg.sv
ps2_line_sampler.sv
ps2_host.sv
ps2_rx_queue.sv
ps2_port_top.sv
ps2_port_chk.sv
tb_ps2_port.sv

// ==== Makefile ====
# Verilator build and run for the PS/2 host port testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_port
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
